// File: include/baton_defines.svh
`ifndef BATON_DEFINES_SVH
`define BATON_DEFINES_SVH

// pixel coordinate widths, enough for 1280 x 720 and more
`define BATON_HCOUNT_W 11
`define BATON_VCOUNT_W 10

// inclusive Cr window for the pink baton tip
`define BATON_CR_LOW  8'hA0
`define BATON_CR_HIGH 8'hF0

// centroid accumulators and divider operands
`define BATON_SUM_W 32

// minimum vertical swing in lines before a direction counts
`define BATON_BEAT_HYST 4

// frames in one minute at 60 fps
`define BATON_FRAMES_PER_MINUTE 3600

// tempo in beats per minute
`define BATON_BPM_W 8

`endif

// File: logic/baton_pkg.sv
`default_nettype none
`include "baton_defines.svh"

package baton_pkg;

   // rgb565 channel split, red in the top bits
   typedef struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } rgb565_chan_t;

   // one camera word seen as raw bytes or as colour channels
   typedef union packed {
      logic [15:0]  raw;
      rgb565_chan_t chan;
   } rgb565_t;

   // one captured pixel with its position in the frame
   typedef struct packed {
      logic                        valid;
      logic [`BATON_HCOUNT_W-1:0]  hcount;
      logic [`BATON_VCOUNT_W-1:0]  vcount;
      rgb565_t                     data;
   } pixel_t;

   // centroid of the marked pixels, found low on an empty frame
   typedef struct packed {
      logic [`BATON_HCOUNT_W-1:0]  x;
      logic [`BATON_VCOUNT_W-1:0]  y;
      logic                        found;
   } centroid_t;

   // tempo source select from the switches
   typedef enum logic [1:0] {
      HOLD   = 2'b00,
      BATON  = 2'b01,
      MANUAL = 2'b10
   } tempo_mode_t;

endpackage

`default_nettype wire

// File: logic/camera_capture.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

// camera bus receiver
// pins are double registered, bytes paired into rgb565 pixels
module camera_capture (
   input  wire                clk_camera,
   input  wire                sys_rst_camera,
   input  wire  [7:0]         cam_data_i,
   input  wire                cam_pclk_i,
   input  wire                cam_hsync_i,
   input  wire                cam_vsync_i,
   output baton_pkg::pixel_t  pixel_o,
   output logic               frame_end_o
);

   // synchronizer stages, packed as {data, pclk, hsync, vsync}
   logic [10:0] sync_s1;
   logic [10:0] sync_s2;
   logic [7:0]  data_s;
   logic        pclk_s;
   logic        hsync_s;
   logic        vsync_s;

   // previous synchronized levels for edge detect
   logic pclk_q;
   logic hsync_q;
   logic vsync_q;
   logic pclk_rise;
   logic hsync_fall;
   logic vsync_rise;

   logic [7:0]                 high_byte;
   logic                       second_byte;
   logic [`BATON_HCOUNT_W-1:0] hcount;
   logic [`BATON_VCOUNT_W-1:0] vcount;

   always_ff @(posedge clk_camera) begin
      sync_s1 <= {cam_data_i, cam_pclk_i, cam_hsync_i, cam_vsync_i};
      sync_s2 <= sync_s1;
   end

   assign {data_s, pclk_s, hsync_s, vsync_s} = sync_s2;

   assign pclk_rise  = pclk_s && !pclk_q;
   assign hsync_fall = !hsync_s && hsync_q;
   assign vsync_rise = vsync_s && !vsync_q;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_q        <= 1'b0;
         hsync_q       <= 1'b0;
         vsync_q       <= 1'b0;
         second_byte   <= 1'b0;
         hcount        <= '0;
         vcount        <= '0;
         pixel_o.valid <= 1'b0;
         frame_end_o   <= 1'b0;
      end else begin
         pclk_q        <= pclk_s;
         hsync_q       <= hsync_s;
         vsync_q       <= vsync_s;
         pixel_o.valid <= 1'b0;
         // frame ends on the vsync rising edge, any frame size works
         frame_end_o   <= vsync_rise;
         if (vsync_rise) begin
            hcount      <= '0;
            vcount      <= '0;
            second_byte <= 1'b0;
         end else if (hsync_fall) begin
            // next line, drop any half pixel
            hcount      <= '0;
            vcount      <= vcount + 1'b1;
            second_byte <= 1'b0;
         end else if (pclk_rise && hsync_s && !vsync_s) begin
            if (!second_byte) begin
               // high byte comes first
               high_byte   <= data_s;
               second_byte <= 1'b1;
            end else begin
               pixel_o.data.raw <= {high_byte, data_s};
               pixel_o.hcount   <= hcount;
               pixel_o.vcount   <= vcount;
               pixel_o.valid    <= 1'b1;
               hcount           <= hcount + 1'b1;
               second_byte      <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/chroma_threshold.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

// rgb565 to Cr conversion and pink window test, one cycle
module chroma_threshold (
   input  wire                               clk_camera,
   input  wire                               sys_rst_camera,
   input  wire baton_pkg::pixel_t            pixel_i,
   input  wire                               frame_end_i,
   output logic                              mark_valid_o,
   output logic                              mark_o,
   output logic [`BATON_HCOUNT_W-1:0]        mark_x_o,
   output logic [`BATON_VCOUNT_W-1:0]        mark_y_o,
   output logic                              frame_end_o
);

   // channels widened to 8 bits
   logic [7:0] red8;
   logic [7:0] green8;
   logic [7:0] blue8;

   // signed weighted sum, magnitude stays under 2^15
   logic signed [17:0] cr_acc;
   logic signed [17:0] cr_full;
   logic [7:0]         cr;
   logic               in_range;

   // green sits in bits 10:5 of the word
   assign red8   = {pixel_i.data.chan.red, 3'b000};
   assign green8 = {pixel_i.data.chan.green, 2'b00};
   assign blue8  = {pixel_i.data.chan.blue, 3'b000};

   assign cr_acc = 18'sd112 * $signed({10'd0, red8})
                 - 18'sd94  * $signed({10'd0, green8})
                 - 18'sd18  * $signed({10'd0, blue8});

   // offset back to unsigned, result lies in 16..239
   assign cr_full  = (cr_acc >>> 8) + 18'sd128;
   assign cr       = cr_full[7:0];
   assign in_range = (cr >= `BATON_CR_LOW) && (cr <= `BATON_CR_HIGH);

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         mark_valid_o <= 1'b0;
         frame_end_o  <= 1'b0;
      end else begin
         mark_valid_o <= pixel_i.valid;
         // delayed with the pixels so the last one lands before it
         frame_end_o  <= frame_end_i;
      end
   end

   always_ff @(posedge clk_camera) begin
      mark_o   <= in_range;
      mark_x_o <= pixel_i.hcount;
      mark_y_o <= pixel_i.vcount;
   end

endmodule

`default_nettype wire

// File: logic/serial_divider.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

// restoring divider, one quotient bit per cycle
// floor quotient, a zero divisor gives all ones
module serial_divider (
   input  wire                      clk_camera,
   input  wire                      sys_rst_camera,
   input  wire                      start_i,
   input  wire  [`BATON_SUM_W-1:0]  dividend_i,
   input  wire  [`BATON_SUM_W-1:0]  divisor_i,
   output logic [`BATON_SUM_W-1:0]  quotient_o,
   output logic                     done_o
);

   logic                             busy;
   logic [$clog2(`BATON_SUM_W)-1:0]  step;
   logic [`BATON_SUM_W-1:0]          divisor_q;
   logic [`BATON_SUM_W-1:0]          rem;
   logic [`BATON_SUM_W:0]            trial;
   logic                             fits;

   // bring down the next dividend bit, which sits at the top of the quotient reg
   assign trial = {rem, quotient_o[`BATON_SUM_W-1]};
   assign fits  = trial >= {1'b0, divisor_q};

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         busy   <= 1'b0;
         step   <= '0;
         done_o <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (!busy) begin
            // start only taken while idle
            if (start_i) begin
               busy <= 1'b1;
               step <= '0;
            end
         end else begin
            step <= step + 1'b1;
            if (step == '1) begin
               busy   <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   // operand and working registers
   always_ff @(posedge clk_camera) begin
      if (!busy && start_i) begin
         divisor_q  <= divisor_i;
         rem        <= '0;
         quotient_o <= dividend_i;
      end else if (busy) begin
         if (fits) begin
            rem <= trial[`BATON_SUM_W-1:0] - divisor_q;
         end else begin
            rem <= trial[`BATON_SUM_W-1:0];
         end
         quotient_o <= {quotient_o[`BATON_SUM_W-2:0], fits};
      end
   end

endmodule

`default_nettype wire

// File: logic/center_of_mass.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

// per frame centroid of marked pixels
// x then y go through one shared divider after frame end
module center_of_mass (
   input  wire                         clk_camera,
   input  wire                         sys_rst_camera,
   input  wire                         mark_valid_i,
   input  wire                         mark_i,
   input  wire  [`BATON_HCOUNT_W-1:0]  mark_x_i,
   input  wire  [`BATON_VCOUNT_W-1:0]  mark_y_i,
   input  wire                         frame_end_i,
   output baton_pkg::centroid_t        centroid_o,
   output logic                        centroid_valid_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_DIV_X,
      S_DIV_Y
   } com_state_t;

   com_state_t state;

   // running sums for the current frame
   logic [`BATON_SUM_W-1:0] acc_x;
   logic [`BATON_SUM_W-1:0] acc_y;
   logic [`BATON_SUM_W-1:0] acc_n;

   // y sum and count kept for the second division
   logic [`BATON_SUM_W-1:0] sum_y_q;
   logic [`BATON_SUM_W-1:0] cnt_q;

   logic                    div_start;
   logic [`BATON_SUM_W-1:0] div_dividend;
   logic [`BATON_SUM_W-1:0] div_divisor;
   logic [`BATON_SUM_W-1:0] div_quotient;
   logic                    div_done;

   // x division starts straight from the live sums at frame end
   assign div_start = (state == S_IDLE && frame_end_i && acc_n != '0)
                   || (state == S_DIV_X && div_done);
   assign div_dividend = (state == S_IDLE) ? acc_x : sum_y_q;
   assign div_divisor  = (state == S_IDLE) ? acc_n : cnt_q;

   serial_divider u_div (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (div_dividend),
      .divisor_i      (div_divisor),
      .quotient_o     (div_quotient),
      .done_o         (div_done)
   );

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state            <= S_IDLE;
         acc_x            <= '0;
         acc_y            <= '0;
         acc_n            <= '0;
         centroid_o       <= '0;
         centroid_valid_o <= 1'b0;
      end else begin
         centroid_valid_o <= 1'b0;
         if (frame_end_i) begin
            sum_y_q <= acc_y;
            cnt_q   <= acc_n;
            acc_x   <= '0;
            acc_y   <= '0;
            acc_n   <= '0;
         end else if (mark_valid_i && mark_i) begin
            acc_x <= acc_x + {{(`BATON_SUM_W-`BATON_HCOUNT_W){1'b0}}, mark_x_i};
            acc_y <= acc_y + {{(`BATON_SUM_W-`BATON_VCOUNT_W){1'b0}}, mark_y_i};
            acc_n <= acc_n + 1'b1;
         end
         case (state)
            S_IDLE: begin
               if (frame_end_i) begin
                  if (acc_n == '0) begin
                     // empty frame, old x and y stay
                     centroid_o.found <= 1'b0;
                     centroid_valid_o <= 1'b1;
                  end else begin
                     state <= S_DIV_X;
                  end
               end
            end
            S_DIV_X: begin
               if (div_done) begin
                  centroid_o.x <= div_quotient[`BATON_HCOUNT_W-1:0];
                  state        <= S_DIV_Y;
               end
            end
            S_DIV_Y: begin
               if (div_done) begin
                  centroid_o.y     <= div_quotient[`BATON_VCOUNT_W-1:0];
                  centroid_o.found <= 1'b1;
                  centroid_valid_o <= 1'b1;
                  state            <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/beat_tracker.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

// beat detect from the vertical baton motion
// turn_y follows the extreme of the current stroke, a swing of
// at least the hysteresis the other way flips the direction
module beat_tracker (
   input  wire                         clk_camera,
   input  wire                         sys_rst_camera,
   input  wire  baton_pkg::centroid_t  centroid_i,
   input  wire                         centroid_valid_i,
   output logic                        beat_o
);

   localparam logic [`BATON_VCOUNT_W-1:0] HYST = `BATON_BEAT_HYST;

   logic [`BATON_VCOUNT_W-1:0] turn_y;
   // high while the baton travels down the image, y growing
   logic                       dir_down;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         turn_y   <= '0;
         dir_down <= 1'b0;
         beat_o   <= 1'b0;
      end else begin
         beat_o <= 1'b0;
         // frames without the baton are skipped
         if (centroid_valid_i && centroid_i.found) begin
            if (dir_down) begin
               if (centroid_i.y > turn_y) begin
                  turn_y <= centroid_i.y;
               end else if (turn_y - centroid_i.y >= HYST) begin
                  // bottom of the stroke, that is the beat
                  dir_down <= 1'b0;
                  turn_y   <= centroid_i.y;
                  beat_o   <= 1'b1;
               end
            end else begin
               if (centroid_i.y < turn_y) begin
                  turn_y <= centroid_i.y;
               end else if (centroid_i.y - turn_y >= HYST) begin
                  dir_down <= 1'b1;
                  turn_y   <= centroid_i.y;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/tempo_estimator.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

// tempo from frames between beats, or manual from the switches
module tempo_estimator (
   input  wire                           clk_camera,
   input  wire                           sys_rst_camera,
   input  wire                           beat_i,
   input  wire                           centroid_valid_i,
   input  wire  baton_pkg::tempo_mode_t  tempo_mode_i,
   input  wire  [`BATON_BPM_W-1:0]       manual_bpm_i,
   output logic [`BATON_BPM_W-1:0]       bpm_o
);

   // frames since the last beat, the beat frame included
   logic [`BATON_SUM_W-1:0] frame_cnt;
   logic                    seen_beat;
   logic                    div_start;
   logic [`BATON_SUM_W-1:0] div_quotient;
   logic                    div_done;
   logic [`BATON_BPM_W-1:0] bpm_sat;

   // first beat only sets the reference point
   assign div_start = beat_i && seen_beat && (tempo_mode_i == baton_pkg::BATON);

   serial_divider u_div (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (`BATON_SUM_W'(`BATON_FRAMES_PER_MINUTE)),
      .divisor_i      (frame_cnt),
      .quotient_o     (div_quotient),
      .done_o         (div_done)
   );

   // clamp to 255 for very short beat intervals
   assign bpm_sat = (div_quotient > `BATON_SUM_W'({`BATON_BPM_W{1'b1}}))
                  ? {`BATON_BPM_W{1'b1}} : div_quotient[`BATON_BPM_W-1:0];

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         frame_cnt <= '0;
         seen_beat <= 1'b0;
         bpm_o     <= '0;
      end else begin
         // beat lags its centroid by a cycle so the count is complete here
         if (beat_i) begin
            frame_cnt <= '0;
            seen_beat <= 1'b1;
         end else if (centroid_valid_i) begin
            frame_cnt <= frame_cnt + 1'b1;
         end
         case (tempo_mode_i)
            baton_pkg::MANUAL: bpm_o <= manual_bpm_i;
            baton_pkg::BATON: begin
               if (div_done) begin
                  bpm_o <= bpm_sat;
               end
            end
            // HOLD keeps the last tempo
            default: bpm_o <= bpm_o;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/baton_tracker_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

// camera side tracking core
// capture -> threshold -> centroid -> beat -> tempo
module baton_tracker_top (
   input  wire                           clk_camera,
   input  wire                           sys_rst_camera,
   input  wire  [7:0]                    cam_data_i,
   input  wire                           cam_pclk_i,
   input  wire                           cam_hsync_i,
   input  wire                           cam_vsync_i,
   input  wire  baton_pkg::tempo_mode_t  tempo_mode_i,
   input  wire  [`BATON_BPM_W-1:0]       manual_bpm_i,
   output baton_pkg::centroid_t          centroid_o,
   output logic                          centroid_valid_o,
   output logic                          beat_o,
   output logic [`BATON_BPM_W-1:0]       bpm_o
);

   baton_pkg::pixel_t          pixel;
   logic                       cap_frame_end;
   logic                       mark_valid;
   logic                       mark;
   logic [`BATON_HCOUNT_W-1:0] mark_x;
   logic [`BATON_VCOUNT_W-1:0] mark_y;
   // frame end aligned with the mark stream
   logic                       thr_frame_end;

   camera_capture u_capture (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .pixel_o        (pixel),
      .frame_end_o    (cap_frame_end)
   );

   chroma_threshold u_threshold (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pixel_i        (pixel),
      .frame_end_i    (cap_frame_end),
      .mark_valid_o   (mark_valid),
      .mark_o         (mark),
      .mark_x_o       (mark_x),
      .mark_y_o       (mark_y),
      .frame_end_o    (thr_frame_end)
   );

   center_of_mass u_com (
      .clk_camera       (clk_camera),
      .sys_rst_camera   (sys_rst_camera),
      .mark_valid_i     (mark_valid),
      .mark_i           (mark),
      .mark_x_i         (mark_x),
      .mark_y_i         (mark_y),
      .frame_end_i      (thr_frame_end),
      .centroid_o       (centroid_o),
      .centroid_valid_o (centroid_valid_o)
   );

   beat_tracker u_beat (
      .clk_camera       (clk_camera),
      .sys_rst_camera   (sys_rst_camera),
      .centroid_i       (centroid_o),
      .centroid_valid_i (centroid_valid_o),
      .beat_o           (beat_o)
   );

   tempo_estimator u_tempo (
      .clk_camera       (clk_camera),
      .sys_rst_camera   (sys_rst_camera),
      .beat_i           (beat_o),
      .centroid_valid_i (centroid_valid_o),
      .tempo_mode_i     (tempo_mode_i),
      .manual_bpm_i     (manual_bpm_i),
      .bpm_o            (bpm_o)
   );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

// 100 ns camera clock, reset held high for the first 5 rising edges
module tb_clock_gen (
   output logic clk_camera_o,
   output logic sys_rst_camera_o
);

   initial begin
      clk_camera_o = 1'b0;
      forever #50 clk_camera_o = ~clk_camera_o;
   end

   initial begin
      sys_rst_camera_o = 1'b1;
      repeat (5) @(posedge clk_camera_o);
      #10;
      sys_rst_camera_o = 1'b0;
   end

endmodule

`default_nettype wire

// File: dv/tb_baton_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "baton_defines.svh"

module tb_baton_top;

   localparam int          MAX_REC          = 64;
   localparam int          CYCLES_PER_PIXEL = 12;
   localparam int          CYCLES_PER_FRAME = 2000;
   localparam logic [31:0] LFSR_SEED        = 32'h0742794b;
   localparam logic [31:0] LFSR_POLY        = 32'h80200003;

   logic                   clk_camera;
   logic                   sys_rst_camera;
   logic [7:0]             cam_data;
   logic                   cam_pclk;
   logic                   cam_hsync;
   logic                   cam_vsync;
   baton_pkg::tempo_mode_t tempo_mode;
   logic [7:0]             manual_bpm;
   baton_pkg::centroid_t   centroid;
   logic                   centroid_valid;
   logic                   beat;
   logic [7:0]             bpm;

   // one stimulus record per line of kind F frame or M mode or P tempo check
   byte         rec_kind [0:MAX_REC-1];
   int          rec_val  [0:MAX_REC-1][0:16];
   int          n_rec;
   logic [31:0] lfsr;
   int          watchdog_cycles;
   bit          watchdog_armed;
   bit          first_frame_done;

   // reference model state
   int prev_x;
   int prev_y;
   int turn_y;
   bit dir_down;
   int frame_cnt;
   bit seen_beat;
   int bpm_model;

   tb_clock_gen u_clk (
      .clk_camera_o     (clk_camera),
      .sys_rst_camera_o (sys_rst_camera)
   );

   baton_tracker_top UUT (
      .clk_camera       (clk_camera),
      .sys_rst_camera   (sys_rst_camera),
      .cam_data_i       (cam_data),
      .cam_pclk_i       (cam_pclk),
      .cam_hsync_i      (cam_hsync),
      .cam_vsync_i      (cam_vsync),
      .tempo_mode_i     (tempo_mode),
      .manual_bpm_i     (manual_bpm),
      .centroid_o       (centroid),
      .centroid_valid_o (centroid_valid),
      .beat_o           (beat),
      .bpm_o            (bpm)
   );

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_centroid(input string name, input baton_pkg::centroid_t exp,
                                 input baton_pkg::centroid_t act);
      string msg;
      if (exp !== act) begin
         msg = $sformatf("MISMATCH %s expected x=%0d y=%0d found=%0d", name, exp.x, exp.y,
                         exp.found);
         msg = {msg, $sformatf(" actual x=%0d y=%0d found=%0d", act.x, act.y, act.found)};
         fail_run(msg);
      end
   endtask

   task automatic check_beat(input string name, input bit exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("MISMATCH %s expected %0b actual %0b", name, exp, act));
      end
   endtask

   task automatic check_bpm(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   // galois lfsr shifting right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   task automatic random_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   // inputs change 10 ns after the rising edge
   task automatic step();
      @(posedge clk_camera);
      #10;
   endtask

   // Cr = 128 + ((112 R - 94 G - 18 B) >>> 8) on 8 bit channels
   function automatic int cr_of(input logic [15:0] w);
      int r8;
      int g8;
      int b8;
      int s;
      r8 = int'(w[15:11]) << 3;
      g8 = int'(w[10:5]) << 2;
      b8 = int'(w[4:0]) << 3;
      s  = 112 * r8 - 94 * g8 - 18 * b8;
      return 128 + (s >>> 8);
   endfunction

   function automatic bit is_pink(input logic [15:0] w);
      int c;
      c = cr_of(w);
      return (c >= int'(`BATON_CR_LOW)) && (c <= int'(`BATON_CR_HIGH));
   endfunction

   // rect b is painted over rect a and both over the background
   function automatic logic [15:0] word_at(input int r, input int x, input int y);
      if (x >= rec_val[r][8] && x <= rec_val[r][10] && y >= rec_val[r][9] && y <= rec_val[r][11])
         return 16'(rec_val[r][12]);
      if (x >= rec_val[r][3] && x <= rec_val[r][5] && y >= rec_val[r][4] && y <= rec_val[r][6])
         return 16'(rec_val[r][7]);
      return 16'(rec_val[r][2]);
   endfunction

   task automatic load_stim();
      int    fd;
      int    code;
      int    pixels;
      int    frames;
      string line;
      int    v [0:16];
      pixels = 0;
      frames = 0;
      n_rec  = 0;
      fd = $fopen("dv/baton_stim.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open dv/baton_stim.txt");
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 0 && line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
            if (line[0] == "F") begin
               code = $sscanf(line, "F %d %d %h %d %d %d %d %h %d %d %d %d %h %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                              v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
               if (code != 17) fail_run("malformed frame line in stimulus file");
               pixels += v[0] * v[1] * v[16];
               frames += v[16];
            end else if (line[0] == "M") begin
               code = $sscanf(line, "M %d %d", v[0], v[1]);
               if (code != 2) fail_run("malformed mode line in stimulus file");
            end else if (line[0] == "P") begin
               code = $sscanf(line, "P %d", v[0]);
               if (code != 1) fail_run("malformed tempo line in stimulus file");
            end else begin
               fail_run("unknown record in stimulus file");
            end
            rec_kind[n_rec] = line[0];
            rec_val[n_rec]  = v;
            n_rec++;
         end
      end
      $fclose(fd);
      // extra frame budget also covers reset and tempo waits
      watchdog_cycles = pixels * CYCLES_PER_PIXEL + (frames + 1) * CYCLES_PER_FRAME;
   endtask

   task automatic drive_byte(input logic [7:0] b);
      int lo;
      int hi;
      random_bits(2, lo);
      random_bits(2, hi);
      cam_data = b;
      cam_pclk = 1'b0;
      repeat (2 + lo) step();
      cam_pclk = 1'b1;
      repeat (2 + hi) step();
   endtask

   task automatic run_frame(input int r, input int rep_no);
      int                   sx;
      int                   sy;
      int                   n;
      int                   q;
      logic [15:0]          w;
      bit                   exp_beat;
      baton_pkg::centroid_t exp;
      string                name;
      sx = 0;
      sy = 0;
      n  = 0;
      exp_beat = 1'b0;
      // model centroid over the pink pixels
      for (int y = 0; y < rec_val[r][1]; y++) begin
         for (int x = 0; x < rec_val[r][0]; x++) begin
            if (is_pink(word_at(r, x, y))) begin
               sx += x;
               sy += y;
               n++;
            end
         end
      end
      if (n > 0) begin
         prev_x = sx / n;
         prev_y = sy / n;
      end
      exp.x     = 11'(prev_x);
      exp.y     = 10'(prev_y);
      exp.found = (n > 0);
      if (prev_x != rec_val[r][13] || prev_y != rec_val[r][14]
          || int'(exp.found) != rec_val[r][15])
         fail_run($sformatf("stimulus file centroid of record %0d disagrees with the model", r));
      // model beat with a direction flip after a swing of the hysteresis
      if (exp.found) begin
         if (dir_down) begin
            if (prev_y > turn_y) begin
               turn_y = prev_y;
            end else if (turn_y - prev_y >= `BATON_BEAT_HYST) begin
               dir_down = 1'b0;
               turn_y   = prev_y;
               exp_beat = 1'b1;
            end
         end else begin
            if (prev_y < turn_y) begin
               turn_y = prev_y;
            end else if (prev_y - turn_y >= `BATON_BEAT_HYST) begin
               dir_down = 1'b1;
               turn_y   = prev_y;
            end
         end
      end
      // lines with the high byte first
      for (int y = 0; y < rec_val[r][1]; y++) begin
         cam_hsync = 1'b1;
         repeat (2) step();
         for (int x = 0; x < rec_val[r][0]; x++) begin
            w = word_at(r, x, y);
            drive_byte(w[15:8]);
            drive_byte(w[7:0]);
         end
         cam_pclk = 1'b0;
         repeat (2) step();
         cam_hsync = 1'b0;
         repeat (4) step();
      end
      // vsync rise ends the frame
      cam_vsync = 1'b1;
      step();
      while (centroid_valid !== 1'b1) step();
      name = $sformatf("record %0d frame %0d centroid", r, rep_no);
      check_centroid(name, exp, centroid);
      first_frame_done = 1'b1;
      step();
      name = $sformatf("record %0d frame %0d beat", r, rep_no);
      check_beat(name, exp_beat, beat);
      cam_vsync = 1'b0;
      repeat (4) step();
      // model tempo
      frame_cnt++;
      if (exp_beat) begin
         if (seen_beat && tempo_mode == baton_pkg::BATON) begin
            q = `BATON_FRAMES_PER_MINUTE / frame_cnt;
            bpm_model = (q > 255) ? 255 : q;
         end
         frame_cnt = 0;
         seen_beat = 1'b1;
      end
   endtask

   task automatic set_mode(input int r);
      tempo_mode = baton_pkg::tempo_mode_t'(rec_val[r][0][1:0]);
      manual_bpm = 8'(rec_val[r][1]);
      if (tempo_mode == baton_pkg::MANUAL) bpm_model = rec_val[r][1];
      step();
   endtask

   task automatic run_tempo_check(input int r);
      int i;
      if (rec_val[r][0] != bpm_model)
         fail_run($sformatf("stimulus file tempo of record %0d disagrees with the model", r));
      // divider result lands some cycles after the beat
      i = 0;
      while (i < 40 && bpm !== 8'(bpm_model)) begin
         step();
         i++;
      end
      check_bpm($sformatf("record %0d tempo", r), 8'(bpm_model), bpm);
   endtask

   // nothing may come out before the first frame ends
   always @(negedge clk_camera) begin
      if (sys_rst_camera === 1'b0 && !first_frame_done) begin
         if (centroid_valid !== 1'b0 || beat !== 1'b0 || bpm !== 8'd0)
            fail_run("DUT output became active before the first frame ended");
      end
   end

   initial begin
      wait (watchdog_armed);
      repeat (watchdog_cycles) @(posedge clk_camera);
      fail_run("timeout waiting for DUT result");
   end

   initial begin
      cam_data         = 8'd0;
      cam_pclk         = 1'b0;
      cam_hsync        = 1'b0;
      cam_vsync        = 1'b0;
      tempo_mode       = baton_pkg::HOLD;
      manual_bpm       = 8'd0;
      lfsr             = LFSR_SEED;
      first_frame_done = 1'b0;
      watchdog_armed   = 1'b0;
      prev_x           = 0;
      prev_y           = 0;
      turn_y           = 0;
      dir_down         = 1'b0;
      frame_cnt        = 0;
      seen_beat        = 1'b0;
      bpm_model        = 0;
      load_stim();
      watchdog_armed = 1'b1;
      @(negedge sys_rst_camera);
      repeat (3) step();
      for (int r = 0; r < n_rec; r++) begin
         if (rec_kind[r] == "F") begin
            for (int k = 0; k < rec_val[r][16]; k++) run_frame(r, k);
         end else if (rec_kind[r] == "M") begin
            set_mode(r);
         end else begin
            run_tempo_check(r);
         end
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
logic/baton_pkg.sv
logic/camera_capture.sv
logic/chroma_threshold.sv
logic/serial_divider.sv
logic/center_of_mass.sv
logic/beat_tracker.sv
logic/tempo_estimator.sv
logic/baton_tracker_top.sv
dv/tb_clock_gen.sv
dv/tb_baton_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the baton tracker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_baton_top \
   -o sim_baton > build.log 2>&1 \
   && ./obj_dir/sim_baton > sim.log 2>&1 \
   || echo "build or run returned an error, see build.log and sim.log"

grep -q "Simulation completed successfully" sim.log 2>/dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// File: dv/baton_stim.txt
# F width height bg ax0 ay0 ax1 ay1 aword bx0 by0 bx1 by1 bword exp_x exp_y exp_found repeat
# M mode(0 hold 1 baton 2 manual) manual_bpm, P expected_bpm
M 1 0
# Cr A0 block is marked, Cr 9F block is not
F 8 12 8410 1 1 2 2 5040 5 5 6 6 5041 1 1 1 1
# empty frame keeps the old position
F 8 12 8410 0 0 0 0 8410 0 0 0 0 8410 1 1 0 1
# down stroke then first beat
F 8 12 8410 2 5 3 6 F800 0 0 0 0 8410 2 5 1 1
F 8 12 8410 2 9 3 10 F800 0 0 0 0 8410 2 9 1 1
F 8 12 8410 2 4 3 5 F800 0 0 0 0 8410 2 4 1 1
# up stroke held still, then a small wobble at the bottom
F 8 12 8410 2 2 3 3 F800 0 0 0 0 8410 2 2 1 11
F 8 12 8410 2 6 3 7 F800 0 0 0 0 8410 2 6 1 1
F 8 12 8410 2 8 3 9 F800 0 0 0 0 8410 2 8 1 1
F 8 12 8410 2 6 3 7 F800 0 0 0 0 8410 2 6 1 1
F 8 12 8410 2 3 3 4 F800 0 0 0 0 8410 2 3 1 1
# 15 frames between beats
P 240
# 2 frames between beats, saturates
F 8 12 8410 2 8 3 9 F800 0 0 0 0 8410 2 8 1 1
F 8 12 8410 2 2 3 3 F800 0 0 0 0 8410 2 2 1 1
P 255
M 0 0
P 255
F 8 12 8410 2 8 3 9 F800 0 0 0 0 8410 2 8 1 1
F 8 12 8410 2 2 3 3 F800 0 0 0 0 8410 2 2 1 1
P 255
M 2 100
P 100
M 1 100
P 100
